// ==== common/bridge_macros.svh ====
`ifndef BRIDGE_MACROS_SVH
`define BRIDGE_MACROS_SVH

// ==============================
// Capture bridge sizing
// ==============================

// Pixel sample width from the sensor side
`define BRIDGE_PIX_WIDTH      12
// Pixel count carried by a line marker
`define BRIDGE_LINE_CNT_WIDTH 14
`define BRIDGE_WORD_WIDTH     16 // One FIFO entry, pixel or marker
// Entries in the clock-crossing FIFO, power of two and >= 4
`define BRIDGE_FIFO_DEPTH     8

`endif

// ==== common/pixPkg.sv ====
`default_nettype none

`include "bridge_macros.svh"

package pixPkg;

    // ==============================
    // Pixel side types
    // ==============================

    typedef logic [`BRIDGE_PIX_WIDTH-1:0]      pixel_t;     // One sample
    typedef logic [`BRIDGE_LINE_CNT_WIDTH-1:0] lineCount_t; // Pixels in a line

    // Unused bits between the flag and the value in a pixel word
    localparam int SpareBits = `BRIDGE_WORD_WIDTH - 1 - `BRIDGE_PIX_WIDTH;

    // ==============================
    // FIFO word views
    // ==============================

    // Pixel view, top bit low
    typedef struct packed {
        logic                 isMarker; // Always 0 here
        logic [SpareBits-1:0] spare;    // Written as zero
        pixel_t               value;
    } pixWord_t;

    // End-of-line marker view, top bit high
    typedef struct packed {
        logic       isMarker; // Always 1 here
        logic       dropped;  // Writer lost at least one pixel
        lineCount_t count;    // Pixels the writer pushed for the line
    } markWord_t;

    // Same 16 bits, decoded by the top bit
    typedef union packed {
        pixWord_t  pix;
        markWord_t mark;
    } fifoWord_u;

endpackage

`default_nettype wire

// ==== common/lineStatPkg.sv ====
`default_nettype none

`include "bridge_macros.svh"

package lineStatPkg;

    // ==============================
    // Per-line result
    // ==============================

    // Status reported with every lineDone pulse
    typedef enum logic [1:0] {
        LINE_OK      = 2'd0, // Every pixel arrived
        LINE_DROPPED = 2'd1, // Writer dropped pixels on a full FIFO
        LINE_SHORT   = 2'd2  // Reader count disagrees with the marker
    } lineStatus_e;

endpackage

`default_nettype wire

// ==== afifo/asyncFifo.sv ====
`timescale 1ns/1ns
`default_nettype none

// Gray pointer dual clock FIFO, flags qualified through two-flop shifters
module asyncFifo #(
    parameter int Width = 16,
    parameter int Depth = 8 // Power of two, at least 4
) (
    input  wire              rclk,     // Read clock
    input  wire              arok,     // Async reset, active low
    input  wire              rtrigger, // Pop request
    output logic [Width-1:0] rdata,    // Head entry, combinational
    output logic             rok,      // Not empty
    input  wire              wclk,     // Write clock
    input  wire              wtrigger, // Push request
    input  wire [Width-1:0]  wdata,    // Word to push
    output logic             wok,      // Not full
    output logic             wrstSync  // Reset released in wclk
);
    localparam int AddrBits = $clog2(Depth);

    logic [Width-1:0] mem [Depth]; // Storage, no reset

    // Read side state
    logic [AddrBits:0] rbaddr;     // Binary read pointer
    logic [AddrBits:0] rgaddr;     // Gray read pointer
    logic [AddrBits:0] rbaddrNext;
    logic [AddrBits:0] wgSync1;    // Write gray pointer, first stage
    logic [AddrBits:0] wgSync2;    // Write gray pointer, usable in rclk
    logic [1:0]        rokReg;     // Not-empty qualifier
    logic              rempty;
    logic              rokHoldN;   // Holds rok low while empty or in reset

    // Write side state
    logic [1:0]        rstSyncReg; // arok release into wclk
    logic [AddrBits:0] wbaddr;     // Binary write pointer
    logic [AddrBits:0] wgaddr;     // Gray write pointer
    logic [AddrBits:0] wbaddrNext;
    logic [AddrBits:0] rgSync1;
    logic [AddrBits:0] rgSync2;    // Read gray pointer, usable in wclk
    logic [1:0]        wokRegN;    // Inverted, 1 means no space
    logic              wfull;
    logic              wokHoldN;

    // ==============================
    // Read side
    // ==============================
    assign rbaddrNext = rbaddr + 1'b1;

    always_ff @(posedge rclk, negedge arok) begin
        if (!arok) begin
            rbaddr <= '0;
            rgaddr <= '0;
        end else if (rtrigger && rok) begin
            rbaddr <= rbaddrNext;
            rgaddr <= (rbaddrNext >> 1) ^ rbaddrNext; // Binary to gray
        end
    end

    // Bring write pointer across
    always_ff @(posedge rclk, negedge arok) begin
        if (!arok) begin
            wgSync1 <= '0;
            wgSync2 <= '0;
        end else begin
            wgSync1 <= wgaddr;
            wgSync2 <= wgSync1;
        end
    end

    assign rempty   = (rgaddr == wgSync2);
    assign rokHoldN = arok & ~rempty;

    // Empty clears at once, data shows after two rclk edges
    always_ff @(posedge rclk, negedge rokHoldN) begin
        if (!rokHoldN) rokReg <= 2'b00;
        else           rokReg <= {rokReg[0], 1'b1};
    end

    assign rok   = rokReg[1];
    assign rdata = mem[rbaddr[AddrBits-1:0]]; // Head of queue

    // ==============================
    // Write side
    // ==============================
    always_ff @(posedge wclk, negedge arok) begin
        if (!arok) rstSyncReg <= 2'b00;
        else       rstSyncReg <= {rstSyncReg[0], 1'b1};
    end

    assign wrstSync   = rstSyncReg[1];
    assign wbaddrNext = wbaddr + 1'b1;

    always_ff @(posedge wclk, negedge wrstSync) begin
        if (!wrstSync) begin
            wbaddr  <= '0;
            wgaddr  <= '0;
            rgSync1 <= '0;
            rgSync2 <= '0;
        end else begin
            rgSync1 <= rgaddr; // Read pointer across
            rgSync2 <= rgSync1;
            if (wtrigger && wok) begin
                wbaddr <= wbaddrNext;
                wgaddr <= (wbaddrNext >> 1) ^ wbaddrNext;
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (wtrigger && wok) mem[wbaddr[AddrBits-1:0]] <= wdata;
    end

    // Full when the top two gray bits differ and the rest match
    assign wfull = (wgaddr == {~rgSync2[AddrBits:AddrBits-1], rgSync2[AddrBits-2:0]});
    assign wokHoldN = arok & ~wfull;

    // Full forces wok low at once, space returns after two wclk edges
    always_ff @(posedge wclk, negedge wokHoldN) begin
        if (!wokHoldN) wokRegN <= 2'b11;
        else           wokRegN <= {wokRegN[0], 1'b0};
    end

    assign wok = ~wokRegN[1];

    // ==============================
    // Checks
    // ==============================
    // A refused pop leaves the read pointer alone
    assert property (@(posedge rclk) disable iff (!arok) !rok |=> $stable(rbaddr))
        else $error("asyncFifo: read pointer moved while empty");

    // A refused push leaves the write pointer alone
    assert property (@(posedge wclk) disable iff (!wrstSync) !wok |=> $stable(wbaddr))
        else $error("asyncFifo: write pointer moved while full");

endmodule

`default_nettype wire

// ==== logic/pixelCapture.sv ====
`timescale 1ns/1ns
`default_nettype none

// wclk side line framer, pushes pixels then an end-of-line marker
module pixelCapture (
    input  wire                  wclk,
    input  wire                  wrstSync,  // Synchronized reset from the FIFO
    input  wire                  pixStrobe, // pixIn valid this cycle
    input  wire pixPkg::pixel_t  pixIn,
    input  wire                  lineEnd,   // Pulse after the last pixel
    input  wire                  wok,       // FIFO has space
    output logic                 wtrigger,  // Push request
    output pixPkg::fifoWord_u    wdata      // Pixel or marker word
);
    pixPkg::lineCount_t lineCnt;     // Pixels pushed in current line
    logic               dropFlag;    // Sticky, current line lost a pixel
    logic               markPending; // Marker waits for space
    pixPkg::lineCount_t pendCnt;     // Frozen count for the marker
    logic               pendDrop;    // Frozen drop flag for the marker
    logic               pixWrite;
    logic               pixDrop;
    logic               markSent;

    // ==============================
    // Push decisions
    // ==============================
    assign pixWrite = pixStrobe && !markPending && wok;   // Pixel goes in now
    assign pixDrop  = pixStrobe && (markPending || !wok); // No room or marker first
    assign markSent = markPending && wok;

    // Marker has priority over any strobed pixel
    assign wtrigger = markPending || pixStrobe;

    always_comb begin
        if (markPending) begin
            wdata.mark = '{isMarker: 1'b1, dropped: pendDrop, count: pendCnt};
        end else begin
            wdata.pix = '{isMarker: 1'b0, spare: '0, value: pixIn};
        end
    end

    // ==============================
    // Line state
    // ==============================
    always_ff @(posedge wclk, negedge wrstSync) begin
        if (!wrstSync) begin
            lineCnt     <= '0;
            dropFlag    <= 1'b0;
            markPending <= 1'b0;
        end else if (lineEnd) begin
            // Close the line, the count restarts for the next one
            lineCnt     <= '0;
            dropFlag    <= 1'b0;
            markPending <= 1'b1;
        end else begin
            if (markSent) markPending <= 1'b0;
            if (pixWrite) lineCnt <= lineCnt + 1'b1;
            if (pixDrop)  dropFlag <= 1'b1; // Lands on next line if marker pending
        end
    end

    // Marker contents, captured on lineEnd
    always_ff @(posedge wclk) begin
        if (lineEnd) begin
            pendCnt  <= lineCnt;
            pendDrop <= dropFlag;
        end
    end

    // Source must keep lineEnd apart from pixel strobes
    assert property (@(posedge wclk) disable iff (!wrstSync) !(pixStrobe && lineEnd))
        else $error("pixelCapture: pixStrobe and lineEnd together");

endmodule

`default_nettype wire

// ==== logic/lineReader.sv ====
`timescale 1ns/1ns
`default_nettype none

// rclk side consumer, drains the FIFO and summarizes each line
module lineReader (
    input  wire                       rclk,
    input  wire                       arok,         // Async reset, active low
    input  wire                       rok,          // FIFO not empty
    input  wire pixPkg::fifoWord_u    rdata,        // Head word
    output logic                      rtrigger,     // Pop request
    output logic                      pixOutStrobe, // pixOut valid
    output pixPkg::pixel_t            pixOut,
    output logic                      lineDone,     // Summary valid
    output pixPkg::lineCount_t        lineLength,   // Pixels received
    output lineStatPkg::lineStatus_e  lineStatus
);
    pixPkg::lineCount_t       rdCnt;      // Pixels received this line
    logic                     popPix;     // Head is a pixel, popping
    logic                     popMark;    // Head is a marker, popping
    lineStatPkg::lineStatus_e markStatus; // Verdict for the head marker

    // No output stall, pop whatever is there
    assign rtrigger = rok;

    // ==============================
    // Word decode
    // ==============================
    assign popPix  = rok && !rdata.pix.isMarker;
    assign popMark = rok && rdata.mark.isMarker;

    // Count mismatch outranks a reported drop
    always_comb begin
        if (rdCnt != rdata.mark.count) begin
            markStatus = lineStatPkg::LINE_SHORT;
        end else if (rdata.mark.dropped) begin
            markStatus = lineStatPkg::LINE_DROPPED;
        end else begin
            markStatus = lineStatPkg::LINE_OK;
        end
    end

    // ==============================
    // Output registers
    // ==============================
    always_ff @(posedge rclk, negedge arok) begin
        if (!arok) begin
            pixOutStrobe <= 1'b0;
            lineDone     <= 1'b0;
            rdCnt        <= '0;
        end else begin
            pixOutStrobe <= popPix;  // One cycle after the pop
            lineDone     <= popMark;
            if (popPix) begin
                rdCnt <= rdCnt + 1'b1;
            end else if (popMark) begin
                rdCnt <= '0;         // Next line starts fresh
            end
        end
    end

    // Data side, only meaningful with its strobe
    always_ff @(posedge rclk) begin
        if (popPix) pixOut <= rdata.pix.value;
        if (popMark) begin
            lineLength <= rdCnt;     // Own count, not the marker's
            lineStatus <= markStatus;
        end
    end

    // One word per pop, so never both outputs at once
    assert property (@(posedge rclk) disable iff (!arok) !(lineDone && pixOutStrobe))
        else $error("lineReader: lineDone with pixOutStrobe");

endmodule

`default_nettype wire

// ==== logic/captureBridge.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bridge_macros.svh"

// Pixel capture bridge, wclk pixels in, rclk pixels and line summaries out
module captureBridge (
    input  wire                      rclk,
    input  wire                      wclk,
    input  wire                      arok,         // Clears both domains
    input  wire                      pixStrobe,
    input  wire pixPkg::pixel_t      pixIn,
    input  wire                      lineEnd,
    output logic                     pixOutStrobe,
    output pixPkg::pixel_t           pixOut,
    output logic                     lineDone,
    output pixPkg::lineCount_t       lineLength,
    output lineStatPkg::lineStatus_e lineStatus
);
    // wclk side
    logic              wtrigger;
    pixPkg::fifoWord_u wdata;
    logic              wok;
    logic              wrstSync;
    // rclk side
    logic              rtrigger;
    pixPkg::fifoWord_u rdata;
    logic              rok;

    pixelCapture capture_i (
        .wclk      (wclk),
        .wrstSync  (wrstSync),
        .pixStrobe (pixStrobe),
        .pixIn     (pixIn),
        .lineEnd   (lineEnd),
        .wok       (wok),
        .wtrigger  (wtrigger),
        .wdata     (wdata)
    );

    asyncFifo #(
        .Width (`BRIDGE_WORD_WIDTH),
        .Depth (`BRIDGE_FIFO_DEPTH)
    ) fifo_i (
        .rclk     (rclk),
        .arok     (arok),
        .rtrigger (rtrigger),
        .rdata    (rdata),
        .rok      (rok),
        .wclk     (wclk),
        .wtrigger (wtrigger),
        .wdata    (wdata),
        .wok      (wok),
        .wrstSync (wrstSync)
    );

    lineReader reader_i (
        .rclk         (rclk),
        .arok         (arok),
        .rok          (rok),
        .rdata        (rdata),
        .rtrigger     (rtrigger),
        .pixOutStrobe (pixOutStrobe),
        .pixOut       (pixOut),
        .lineDone     (lineDone),
        .lineLength   (lineLength),
        .lineStatus   (lineStatus)
    );

endmodule

`default_nettype wire

// ==== dv/captureBridgeTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "bridge_macros.svh"

// Self-checking testbench for the pixel capture bridge
module captureBridgeTb;
    localparam int OvfLen    = 8 * `BRIDGE_FIFO_DEPTH;          // Sure to overrun the FIFO
    localparam int MaxPixels = 8 + 20 * 40 + OvfLen + 32 + 16;  // Bound over all tests
    localparam int WatchdogCycles = MaxPixels * 8 + 200;        // In rclk periods

    logic                     rclk = 1'b0;
    logic                     wclk = 1'b0;
    logic                     arok;
    logic                     pixStrobe;
    pixPkg::pixel_t           pixIn;
    logic                     lineEnd;
    logic                     pixOutStrobe;
    pixPkg::pixel_t           pixOut;
    logic                     lineDone;
    pixPkg::lineCount_t       lineLength;
    lineStatPkg::lineStatus_e lineStatus;

    logic [31:0]              lfsr = 32'h3f7c;
    pixPkg::pixel_t           sentPix[$]; // All strobed pixels, in order
    pixPkg::pixel_t           rxPix[$];   // Current line as received
    string                    lineName[$];
    int                       lineLen[$];
    bit                       lineOvf[$]; // Line may lose pixels
    int                       curLen = 0;
    int                       linesSent = 0;
    int                       linesRcvd = 0;
    int                       errCount = 0;
    int                       testsRun = 0;
    int                       testsFailed = 0;
    bit                       anySent = 1'b0;
    lineStatPkg::lineStatus_e lastStatus;

    captureBridge dut_i (
        .rclk         (rclk),
        .wclk         (wclk),
        .arok         (arok),
        .pixStrobe    (pixStrobe),
        .pixIn        (pixIn),
        .lineEnd      (lineEnd),
        .pixOutStrobe (pixOutStrobe),
        .pixOut       (pixOut),
        .lineDone     (lineDone),
        .lineLength   (lineLength),
        .lineStatus   (lineStatus)
    );

    always #20 rclk = ~rclk;
    always #10 wclk = ~wclk; // Writer twice as fast as reader

    // ==============================
    // Random source and reference
    // ==============================
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // Galois form
    endfunction

    // One LFSR step per bit taken
    task automatic randBits(input int n, output int unsigned v);
        v = 0;
        repeat (n) begin
            lfsr = lfsrStep(lfsr);
            v = (v << 1) | lfsr[0];
        end
    endtask

    // Expected summary of a line, returns 0 if the received order is impossible
    function automatic bit refLine(input pixPkg::pixel_t sent[$], input bit mayOvf,
                                   input pixPkg::pixel_t got[$],
                                   output pixPkg::lineCount_t expLen,
                                   output lineStatPkg::lineStatus_e expStat);
        int j;
        j = 0;
        if (!mayOvf) begin
            expLen  = sent.size();
            expStat = lineStatPkg::LINE_OK;
            if (got.size() != sent.size()) return 1'b0;
            foreach (got[i]) begin
                if (got[i] !== sent[i]) return 1'b0;
            end
            return 1'b1;
        end
        expLen  = got.size();                      // Writer pushed what arrived
        expStat = (got.size() < sent.size()) ? lineStatPkg::LINE_DROPPED
                                             : lineStatPkg::LINE_OK;
        foreach (got[i]) begin
            while (j < sent.size() && sent[j] !== got[i]) j++; // Skip dropped ones
            if (j == sent.size()) return 1'b0;
            j++;
        end
        return 1'b1;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic checkPixel(input string name, input pixPkg::pixel_t exp,
                              input pixPkg::pixel_t got);
        if (got !== exp) begin
            errCount++;
            $display("** Error %s: pixel expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic checkLength(input string name, input pixPkg::lineCount_t exp,
                               input pixPkg::lineCount_t got);
        if (got !== exp) begin
            errCount++;
            $display("** Error %s: lineLength expected %0d, got %0d", name, exp, got);
        end
    endtask

    task automatic checkStatus(input string name, input lineStatPkg::lineStatus_e exp,
                               input lineStatPkg::lineStatus_e got);
        if (got !== exp) begin
            errCount++;
            $display("** Error %s: lineStatus expected %s, got %s (%0d)", name,
                     exp.name(), got.name(), got);
        end
    endtask

    task automatic checkLevel(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            errCount++;
            $display("** Error %s: level expected %b, got %b", name, exp, got);
        end
    endtask

    // Called on each lineDone, matches the oldest outstanding line
    task automatic compareLine();
        pixPkg::pixel_t           sent[$];
        pixPkg::lineCount_t       expLen;
        lineStatPkg::lineStatus_e expStat;
        string                    name;
        bit                       ovf;
        int                       n;
        if (lineName.size() == 0) begin
            errCount++;
            $display("A lineDone arrived with no line outstanding");
        end else begin
            name = lineName.pop_front();
            n    = lineLen.pop_front();
            ovf  = lineOvf.pop_front();
            repeat (n) sent.push_back(sentPix.pop_front());
            if (!refLine(sent, ovf, rxPix, expLen, expStat)) begin
                errCount++;
                $display("%s: received %0d pixels out of %0d sent are not in send order",
                         name, rxPix.size(), n);
            end
            checkLength(name, expLen, lineLength);
            checkStatus(name, expStat, lineStatus);
            if (!ovf) begin
                for (int i = 0; i < n && i < rxPix.size(); i++) begin
                    checkPixel(name, sent[i], rxPix[i]);
                end
            end
        end
        lastStatus = lineStatus;
        rxPix.delete();
        linesRcvd++;
    endtask

    // Outputs sampled mid-cycle, away from the rclk edge
    always @(negedge rclk) begin
        if (pixOutStrobe === 1'b1) rxPix.push_back(pixOut);
        if (lineDone === 1'b1) compareLine();
        if (!anySent) begin // Quiet outputs until the first pixel
            checkLevel("reset pixOutStrobe", 1'b0, pixOutStrobe);
            checkLevel("reset lineDone", 1'b0, lineDone);
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge wclk);
            pixStrobe <= 1'b0;
            lineEnd   <= 1'b0;
        end
    endtask

    task automatic sendPixel(input pixPkg::pixel_t v);
        @(posedge wclk);
        pixStrobe <= 1'b1;
        pixIn     <= v;
        lineEnd   <= 1'b0;
        sentPix.push_back(v);
        curLen++;
        anySent = 1'b1;
    endtask

    // Line record goes out with the lineEnd pulse
    task automatic endLine(input string name, input bit mayOvf);
        @(posedge wclk);
        pixStrobe <= 1'b0;
        lineEnd   <= 1'b1;
        lineName.push_back(name);
        lineLen.push_back(curLen);
        lineOvf.push_back(mayOvf);
        curLen = 0;
        linesSent++;
    endtask

    task automatic sendPacedLine(input string name, input int n);
        int unsigned v;
        for (int i = 0; i < n; i++) begin
            randBits(`BRIDGE_PIX_WIDTH, v);
            sendPixel(v[`BRIDGE_PIX_WIDTH-1:0]);
            randBits(2, v);
            idle(3 + v); // 3 to 6 idle wclk cycles
        end
        endLine(name, 1'b0);
        randBits(2, v);
        idle(3 + v);
    endtask

    task automatic waitLines(input string name);
        int cycles;
        cycles = 0;
        while (linesRcvd < linesSent && cycles < 300) begin
            @(posedge rclk);
            cycles++;
        end
        if (linesRcvd < linesSent) begin
            errCount++;
            $display("%s: lineDone missing for %0d line(s)", name, linesSent - linesRcvd);
            lineName.delete();
            lineLen.delete();
            lineOvf.delete();
            sentPix.delete();
            linesRcvd = linesSent;
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        testsRun++;
        if (errCount == errBefore) begin
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: failed with %0d error(s)", name, errCount - errBefore);
        end
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        int unsigned v;
        int          e;
        int          doneMark;
        bit          strobedEarly;
        arok      = 1'b0;
        pixStrobe = 1'b0;
        pixIn     = '0;
        lineEnd   = 1'b0;

        e = errCount;
        repeat (3) @(posedge rclk);
        arok <= 1'b1;
        repeat (20) @(posedge rclk); // Covers the wclk reset release too
        finishTest("reset", e);

        e = errCount;
        sendPacedLine("shortLine", 8);
        waitLines("shortLine");
        finishTest("shortLine", e);

        e = errCount;
        for (int i = 0; i < 20; i++) begin
            randBits(6, v);
            sendPacedLine($sformatf("randomLines[%0d]", i), 1 + v % 40);
        end
        waitLines("randomLines");
        finishTest("randomLines", e);

        e = errCount;
        for (int i = 0; i < OvfLen; i++) begin
            randBits(`BRIDGE_PIX_WIDTH, v);
            sendPixel(v[`BRIDGE_PIX_WIDTH-1:0]); // Every wclk cycle
        end
        endLine("overflow", 1'b1);
        idle(2);
        waitLines("overflow");
        checkStatus("overflow", lineStatPkg::LINE_DROPPED, lastStatus);
        finishTest("overflow", e);

        // Fill the FIFO, end the line while full, then go straight on
        e = errCount;
        for (int i = 0; i < 32; i++) begin
            randBits(`BRIDGE_PIX_WIDTH, v);
            sendPixel(v[`BRIDGE_PIX_WIDTH-1:0]);
        end
        endLine("pendingMarker[0]", 1'b1);
        doneMark     = linesRcvd;
        strobedEarly = 1'b0;
        for (int i = 0; i < 16; i++) begin
            if (linesRcvd == doneMark) strobedEarly = 1'b1; // Marker may still wait
            randBits(`BRIDGE_PIX_WIDTH, v);
            sendPixel(v[`BRIDGE_PIX_WIDTH-1:0]);
            randBits(2, v);
            idle(3 + v);
        end
        endLine("pendingMarker[1]", strobedEarly);
        idle(4);
        waitLines("pendingMarker");
        finishTest("pendingMarker", e);

        e = errCount;
        endLine("emptyLine", 1'b0);
        idle(4);
        waitLines("emptyLine");
        finishTest("emptyLine", e);

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        repeat (WatchdogCycles) @(posedge rclk);
        $display("Watchdog expired after %0d rclk cycles, the run did not complete",
                 WatchdogCycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+common
common/pixPkg.sv
common/lineStatPkg.sv
afifo/asyncFifo.sv
logic/pixelCapture.sv
logic/lineReader.sv
logic/captureBridge.sv
dv/captureBridgeTb.sv
